/* common/mc_addr_pkg.sv */
// address map shared by the remote-access path of one tile
// pod geometry, vcache striping constants and the eva/npa layouts
// imported by the translator, the dram hash and the axi adapter
package mc_addr_pkg;

  // pod geometry in tiles
  localparam int num_tiles_x_gp = 4;
  localparam int num_tiles_y_gp = 4;
  localparam int x_subcord_width_gp = $clog2(num_tiles_x_gp); // 2
  localparam int y_subcord_width_gp = $clog2(num_tiles_y_gp); // 2

  // pod coordinates sit above the subcoordinates
  localparam int pod_x_cord_width_gp = 3;
  localparam int pod_y_cord_width_gp = 4;
  localparam int x_cord_width_gp = pod_x_cord_width_gp + x_subcord_width_gp; // 5
  localparam int y_cord_width_gp = pod_y_cord_width_gp + y_subcord_width_gp; // 6

  localparam int addr_width_gp = 16; // epa, word address

  // vcache side of the pod
  localparam int vcache_block_size_in_words_gp = 8;
  localparam int num_vcache_rows_gp = 1; // per side
  localparam int vcache_word_offset_width_gp = $clog2(vcache_block_size_in_words_gp);
  localparam int vcache_row_id_width_gp = $clog2(2 * num_vcache_rows_gp); // north/south

  // dram eva split, word address is eva[30:2]
  localparam int eva_word_addr_width_gp = 29;
  localparam int dram_block_width_gp = eva_word_addr_width_gp - vcache_word_offset_width_gp;
  localparam int dram_stripe_width_gp = x_subcord_width_gp + vcache_row_id_width_gp; // 3

  // direct-mapped classes
  localparam int global_epa_word_addr_width_gp = 16;
  localparam int tile_group_epa_word_addr_width_gp = 15;
  localparam int eva_cord_width_gp = 6; // coordinate fields in the eva

  localparam logic [1:0] global_remote_gc = 2'b01;
  localparam logic [2:0] tile_group_remote_gc = 3'b001;

  // global eva, coordinates encoded directly
  typedef struct packed {
    logic [1:0] remote;                          // 01
    logic [eva_cord_width_gp-1:0] y_cord;
    logic [eva_cord_width_gp-1:0] x_cord;        // low 5 bits used
    logic [global_epa_word_addr_width_gp-1:0] addr;
    logic [1:0] byte_ofs;
  } global_addr_s;

  // tile-group eva, coordinates relative to the group origin
  typedef struct packed {
    logic [2:0] remote;                          // 001
    logic [eva_cord_width_gp-1:0] y_cord;
    logic [eva_cord_width_gp-1:0] x_cord;
    logic [tile_group_epa_word_addr_width_gp-1:0] addr;
    logic [1:0] byte_ofs;
  } tile_group_addr_s;

  // network physical address
  typedef struct packed {
    logic [x_cord_width_gp-1:0] x_cord;
    logic [y_cord_width_gp-1:0] y_cord;
    logic [addr_width_gp-1:0] epa;
  } npa_s;

endpackage

/* common/mc_bus_pkg.sv */
// bus-side types for the remote-access path
// axi4-lite request/response bundles and the mesh packet formats
// the adapter and the top level carry these as single ports
package mc_bus_pkg;

  // axi response codes
  localparam logic [1:0] resp_okay_gc = 2'd0;
  localparam logic [1:0] resp_slverr_gc = 2'd2;

  // driven by the axi master
  typedef struct packed {
    logic [31:0] awaddr;
    logic awvalid;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic bready;
    logic [31:0] araddr;
    logic arvalid;
    logic rready;
  } axil_req_s;

  // driven by the axi slave
  typedef struct packed {
    logic awready;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
  } axil_rsp_s;

  typedef enum logic [1:0] {
    op_load,
    op_store
  } net_op_e;

  // one mesh request
  typedef struct packed {
    net_op_e op;
    mc_addr_pkg::npa_s npa;
    logic [31:0] data;  // store data
    logic [3:0] mask;   // byte enables
  } net_pkt_s;

  // load data, zero on store
  typedef struct packed {
    logic [31:0] data;
  } net_rsp_s;

endpackage

/* eva_to_npa/dram_hash.sv */
// dram hash for the remote path, purely combinational
// stripes dram words across the north and south vcaches one block at a time
// and forms the vcache-local word address
`timescale 1ns/1ps

module dram_hash (
  input  logic [31:0]                             eva_i,   // byte address
  input  logic [mc_addr_pkg::pod_x_cord_width_gp-1:0] pod_x_i,
  input  logic [mc_addr_pkg::pod_y_cord_width_gp-1:0] pod_y_i,
  output mc_addr_pkg::npa_s                       npa_o
);

  import mc_addr_pkg::*;

  logic [eva_word_addr_width_gp-1:0] word_addr;
  logic [vcache_word_offset_width_gp-1:0] word_ofs;   // word within block
  logic [dram_block_width_gp-1:0] block;               // block number
  logic [dram_stripe_width_gp-1:0] stripe;             // which vcache
  logic [dram_block_width_gp-dram_stripe_width_gp-1:0] set_idx; // block within one vcache
  logic [x_subcord_width_gp-1:0] x_sub;
  logic is_south;

  assign word_addr = eva_i[30:2]; // bit 31 is the dram tag
  assign word_ofs = word_addr[vcache_word_offset_width_gp-1:0];
  assign block = word_addr[eva_word_addr_width_gp-1:vcache_word_offset_width_gp];

  // low block bits pick the vcache
  assign stripe = block[dram_stripe_width_gp-1:0];
  assign x_sub = stripe[x_subcord_width_gp-1:0];        // column
  assign is_south = stripe[dram_stripe_width_gp-1];     // 0 north, 1 south
  assign set_idx = block[dram_block_width_gp-1:dram_stripe_width_gp];

  always_comb begin
    npa_o.x_cord = {pod_x_i, x_sub};

    // vcache rows sit just outside the pod
    if (is_south) begin
      npa_o.y_cord = {pod_y_cord_width_gp'(pod_y_i + 1'b1), {y_subcord_width_gp{1'b0}}};
    end else begin
      npa_o.y_cord = {pod_y_cord_width_gp'(pod_y_i - 1'b1), {y_subcord_width_gp{1'b1}}};
    end

    // stripe bits dropped, block re-scaled to words, upper bits cut off
    npa_o.epa = addr_width_gp'({set_idx, word_ofs});
  end

endmodule

/* eva_to_npa/eva_to_npa.sv */
// eva to npa translation for the remote-access path
// covers the classes common to every endpoint: dram, global and tile-group
// anything else is flagged invalid with an all-zero npa
// combinational, the eva is translated in the same cycle
`timescale 1ns/1ps

module eva_to_npa (
  input  logic [31:0]                                 eva_i,    // byte address
  input  logic [mc_addr_pkg::x_subcord_width_gp-1:0]  tgo_x_i,  // tile-group origin
  input  logic [mc_addr_pkg::y_subcord_width_gp-1:0]  tgo_y_i,
  input  logic [mc_addr_pkg::pod_x_cord_width_gp-1:0] pod_x_i,
  input  logic [mc_addr_pkg::pod_y_cord_width_gp-1:0] pod_y_i,
  output mc_addr_pkg::npa_s                           npa_o,
  output logic                                        is_invalid_addr_o
);

  import mc_addr_pkg::*;

  global_addr_s global_addr;
  tile_group_addr_s tile_group_addr;
  npa_s dram_npa;
  logic is_dram;
  logic is_global;
  logic is_tile_group;

  // same word seen through both layouts
  assign global_addr = global_addr_s'(eva_i);
  assign tile_group_addr = tile_group_addr_s'(eva_i);

  assign is_dram = eva_i[31];
  assign is_global = (global_addr.remote == global_remote_gc);
  assign is_tile_group = (tile_group_addr.remote == tile_group_remote_gc);

  // dram striping
  dram_hash u_dram_hash (
    .eva_i   (eva_i),
    .pod_x_i (pod_x_i),
    .pod_y_i (pod_y_i),
    .npa_o   (dram_npa)
  );

  // priority follows the tag length, dram tag is a single bit
  always_comb begin
    npa_o = '0;
    is_invalid_addr_o = 1'b0;

    if (is_dram) begin
      npa_o = dram_npa;
    end else if (is_global) begin
      // coordinates taken as they are
      npa_o.x_cord = x_cord_width_gp'(global_addr.x_cord);
      npa_o.y_cord = y_cord_width_gp'(global_addr.y_cord);
      npa_o.epa = addr_width_gp'(global_addr.addr);
    end else if (is_tile_group) begin
      // offset from the group origin, wraps inside the pod
      npa_o.x_cord = {pod_x_i, x_subcord_width_gp'(tile_group_addr.x_cord + tgo_x_i)};
      npa_o.y_cord = {pod_y_i, y_subcord_width_gp'(tile_group_addr.y_cord + tgo_y_i)};
      npa_o.epa = addr_width_gp'(tile_group_addr.addr);
    end else begin
      is_invalid_addr_o = 1'b1; // no remote mapping
    end
  end

endmodule

/* verilog/axil_remote_adapter.sv */
// axi4-lite slave that turns one access into one mesh request
// translates the eva, sends the packet, waits for the network response,
// then answers on b or r; one transaction in flight at a time
// invalid addresses are answered with slverr and never reach the mesh
`timescale 1ns/1ps

module axil_remote_adapter (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  mc_bus_pkg::axil_req_s                       axil_req_i,
  output mc_bus_pkg::axil_rsp_s                       axil_rsp_o,
  output mc_bus_pkg::net_pkt_s                        pkt_o,
  output logic                                        pkt_v_o,
  input  logic                                        pkt_ready_i,
  input  mc_bus_pkg::net_rsp_s                        rsp_i,
  input  logic                                        rsp_v_i,
  input  logic [mc_addr_pkg::x_subcord_width_gp-1:0]  tgo_x_i,
  input  logic [mc_addr_pkg::y_subcord_width_gp-1:0]  tgo_y_i,
  input  logic [mc_addr_pkg::pod_x_cord_width_gp-1:0] pod_x_i,
  input  logic [mc_addr_pkg::pod_y_cord_width_gp-1:0] pod_y_i
);

  import mc_addr_pkg::*;
  import mc_bus_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    SEND,      // packet offered to the mesh
    WAIT_RSP,  // packet taken, waiting for the response strobe
    RESP_B,
    RESP_R
  } state_e;

  state_e state_q, state_n;
  logic rdy_q;                 // accepting, low through reset
  logic wr_pend;               // aw and w both present
  logic wr_fire;
  logic rd_fire;
  logic [31:0] eva;
  npa_s npa_lo;
  logic invalid_lo;
  net_pkt_s pkt_q;
  logic is_read_q;
  logic [1:0] resp_q;          // shared by b and r
  logic [31:0] rdata_q;

  // write wins when both channels are pending
  assign wr_pend = axil_req_i.awvalid & axil_req_i.wvalid;
  assign wr_fire = rdy_q & wr_pend;
  assign rd_fire = rdy_q & axil_req_i.arvalid & ~wr_pend;
  assign eva = wr_pend ? axil_req_i.awaddr : axil_req_i.araddr;

  eva_to_npa u_eva_to_npa (
    .eva_i             (eva),
    .tgo_x_i           (tgo_x_i),
    .tgo_y_i           (tgo_y_i),
    .pod_x_i           (pod_x_i),
    .pod_y_i           (pod_y_i),
    .npa_o             (npa_lo),
    .is_invalid_addr_o (invalid_lo)
  );

  always_comb begin
    state_n = state_q;
    case (state_q)
      IDLE: begin
        if (wr_fire) begin
          state_n = invalid_lo ? RESP_B : SEND;
        end else if (rd_fire) begin
          state_n = invalid_lo ? RESP_R : SEND;
        end
      end
      SEND:     if (pkt_ready_i) state_n = WAIT_RSP;
      WAIT_RSP: if (rsp_v_i) state_n = is_read_q ? RESP_R : RESP_B;
      RESP_B:   if (axil_req_i.bready) state_n = IDLE;
      RESP_R:   if (axil_req_i.rready) state_n = IDLE;
      default:  state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      rdy_q <= 1'b0;
    end else begin
      state_q <= state_n;
      rdy_q <= (state_n == IDLE); // readies follow the next state
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin
    if (wr_fire || rd_fire) begin
      pkt_q.op <= wr_fire ? op_store : op_load;
      pkt_q.npa <= npa_lo;
      pkt_q.data <= wr_fire ? axil_req_i.wdata : 32'd0;
      pkt_q.mask <= wr_fire ? axil_req_i.wstrb : 4'hf; // loads fetch the whole word
      is_read_q <= rd_fire;
      resp_q <= invalid_lo ? resp_slverr_gc : resp_okay_gc;
      rdata_q <= '0;                                     // stays zero on slverr
    end else if (state_q == WAIT_RSP && rsp_v_i && is_read_q) begin
      rdata_q <= rsp_i.data;
    end
  end

  assign pkt_o = pkt_q;
  assign pkt_v_o = (state_q == SEND);

  always_comb begin
    axil_rsp_o.awready = rdy_q;
    axil_rsp_o.wready = rdy_q;
    axil_rsp_o.arready = rdy_q & ~wr_pend; // held off while a write is pending
    axil_rsp_o.bvalid = (state_q == RESP_B);
    axil_rsp_o.bresp = resp_q;
    axil_rsp_o.rvalid = (state_q == RESP_R);
    axil_rsp_o.rresp = resp_q;
    axil_rsp_o.rdata = rdata_q;
  end

endmodule

/* verilog/remote_access_top.sv */
// top level of the tile's remote-access path
// axi4-lite slave port in, mesh request/response ports out
// configuration inputs are held static while traffic runs
`timescale 1ns/1ps

module remote_access_top (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  mc_bus_pkg::axil_req_s                       axil_req_i,   // host side
  output mc_bus_pkg::axil_rsp_s                       axil_rsp_o,
  output mc_bus_pkg::net_pkt_s                        pkt_o,        // mesh request
  output logic                                        pkt_v_o,
  input  logic                                        pkt_ready_i,
  input  mc_bus_pkg::net_rsp_s                        rsp_i,        // mesh response
  input  logic                                        rsp_v_i,
  input  logic [mc_addr_pkg::x_subcord_width_gp-1:0]  tgo_x_i,      // tile-group origin
  input  logic [mc_addr_pkg::y_subcord_width_gp-1:0]  tgo_y_i,
  input  logic [mc_addr_pkg::pod_x_cord_width_gp-1:0] pod_x_i,      // this pod
  input  logic [mc_addr_pkg::pod_y_cord_width_gp-1:0] pod_y_i
);

  // axi sequencer with the translator inside
  axil_remote_adapter u_adapter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .pkt_o       (pkt_o),
    .pkt_v_o     (pkt_v_o),
    .pkt_ready_i (pkt_ready_i),
    .rsp_i       (rsp_i),
    .rsp_v_i     (rsp_v_i),
    .tgo_x_i     (tgo_x_i),
    .tgo_y_i     (tgo_y_i),
    .pod_x_i     (pod_x_i),
    .pod_y_i     (pod_y_i)
  );

endmodule

/* testbench/remote_access_chk.sv */
// handshake assertions for the axi4-lite remote adapter
// bound into every axil_remote_adapter instance from the bottom of this file
`timescale 1ns/1ps

module remote_access_chk (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input mc_bus_pkg::axil_req_s axil_req_i,
  input mc_bus_pkg::axil_rsp_s axil_rsp_i,
  input mc_bus_pkg::net_pkt_s  pkt_i,
  input logic                  pkt_v_i,
  input logic                  pkt_ready_i
);

  // mesh request held with a stable payload until taken
  a_pkt_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pkt_v_i && !pkt_ready_i |=> pkt_v_i && $stable(pkt_i))
    else $error("pkt_v_o dropped or pkt_o changed before pkt_ready_i");

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid && $stable(axil_rsp_i.bresp))
    else $error("bvalid dropped or bresp changed before bready");

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata))
    else $error("rvalid dropped or rdata changed before rready");

  // one phase at a time
  a_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(pkt_v_i && (axil_rsp_i.bvalid || axil_rsp_i.rvalid)))
    else $error("pkt_v_o high together with bvalid or rvalid");

endmodule

bind axil_remote_adapter remote_access_chk u_chk (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .axil_req_i  (axil_req_i),
  .axil_rsp_i  (axil_rsp_o),
  .pkt_i       (pkt_o),
  .pkt_v_i     (pkt_v_o),
  .pkt_ready_i (pkt_ready_i)
);

/* testbench/tb_remote_access.sv */
// testbench for the tile's remote-access path
// random axi4-lite stores and loads over every eva class, a mesh responder with a
// word memory, and a reference translator for the expected npa
`timescale 1ns/1ps

module tb_remote_access;

  import mc_addr_pkg::*;
  import mc_bus_pkg::*;

  localparam int num_tests_c = 5;     // reset check plus four random runs
  localparam int accesses_c = 200;    // per random run
  localparam int watchdog_ns_c = accesses_c * 30 * 40 * num_tests_c;

  logic clk_i;
  logic rst_n_i;
  axil_req_s req;
  axil_rsp_s rsp;
  net_pkt_s pkt;
  logic pkt_v;
  logic pkt_ready;
  net_rsp_s net_rsp;
  logic net_rsp_v;
  logic [x_subcord_width_gp-1:0] tgo_x;
  logic [y_subcord_width_gp-1:0] tgo_y;
  logic [pod_x_cord_width_gp-1:0] pod_x;
  logic [pod_y_cord_width_gp-1:0] pod_y;

  integer seed = 32'hc66f;
  int errors = 0;
  int pkt_cnt = 0;                       // packets taken by the responder
  net_pkt_s last_pkt;
  logic [31:0] net_mem [logic [26:0]];   // responder memory, keyed by packet npa
  logic [31:0] exp_mem [logic [26:0]];   // expected contents, keyed by reference npa

  remote_access_top dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .axil_req_i  (req),
    .axil_rsp_o  (rsp),
    .pkt_o       (pkt),
    .pkt_v_o     (pkt_v),
    .pkt_ready_i (pkt_ready),
    .rsp_i       (net_rsp),
    .rsp_v_i     (net_rsp_v),
    .tgo_x_i     (tgo_x),
    .tgo_y_i     (tgo_y),
    .pod_x_i     (pod_x),
    .pod_y_i     (pod_y)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    #(watchdog_ns_c);
    $display("watchdog expired, the run hung after %0d packets", pkt_cnt);
    $display("Test failed");
    $finish;
  end

  // inputs change and outputs are read 2 ns after the edge
  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic ready_draw();
    logic [31:0] r;
    r = rnd();
    return r[1:0] != 2'd0; // ready three cycles in four
  endfunction

  task automatic report_fail(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("FAIL %s: expected %h, got %h", name, exp, got);
    errors++;
  endtask

  // expected npa straight from the address-map rules
  function automatic npa_s ref_npa(input logic [31:0] eva, output logic bad);
    npa_s n;
    logic [28:0] word;
    logic [25:0] blk;
    n = '0;
    bad = 1'b0;
    word = eva[30:2];
    blk = word[28:3];                       // 8-word blocks
    if (eva[31]) begin
      n.x_cord = {pod_x, blk[1:0]};
      n.y_cord = blk[2] ? {pod_y + 4'd1, 2'd0} : {pod_y - 4'd1, 2'd3}; // south : north
      n.epa = {blk[15:3], word[2:0]};       // stripe bits gone, offset kept
    end else if (eva[31:30] == 2'b01) begin
      n.x_cord = eva[22:18];
      n.y_cord = eva[29:24];
      n.epa = eva[17:2];
    end else if (eva[31:29] == 3'b001) begin
      n.x_cord = {pod_x, eva[18:17] + tgo_x}; // wraps mod 4
      n.y_cord = {pod_y, eva[24:23] + tgo_y};
      n.epa = {1'b0, eva[16:2]};
    end else begin
      bad = 1'b1;
    end
    return n;
  endfunction

  // one axi store or load, checked on the mesh side and the response channel
  task automatic access(input logic is_write, input logic [31:0] eva, input logic [31:0] data,
                        input logic [3:0] strb);
    npa_s exp_npa;
    logic bad;
    logic [26:0] key;
    int cnt0;
    logic [1:0] exp_resp;
    logic [31:0] exp_rdata;
    net_op_e exp_op;
    exp_npa = ref_npa(eva, bad);
    key = exp_npa;
    cnt0 = pkt_cnt;
    exp_resp = bad ? resp_slverr_gc : resp_okay_gc;
    exp_rdata = (!bad && exp_mem.exists(key)) ? exp_mem[key] : 32'd0;
    exp_op = is_write ? op_store : op_load;
    if (is_write) begin
      req.awaddr = eva;
      req.wdata = data;
      req.wstrb = strb;
      req.awvalid = 1'b1;
      req.wvalid = 1'b1;
      while (!rsp.awready) tick(); // aw and w go together
    end else begin
      req.araddr = eva;
      req.arvalid = 1'b1;
      while (!rsp.arready) tick();
    end
    tick();
    req.awvalid = 1'b0;
    req.wvalid = 1'b0;
    req.arvalid = 1'b0;
    if (bad && !(is_write ? rsp.bvalid : rsp.rvalid)) begin
      $display("no error response one cycle after accepting invalid eva %h", eva);
      errors++;
    end
    if (!bad && !pkt_v) begin
      $display("no packet one cycle after accepting eva %h", eva);
      errors++;
    end
    forever begin
      req.bready = is_write & ready_draw();
      req.rready = ~is_write & ready_draw();
      if ((rsp.bvalid & req.bready) | (rsp.rvalid & req.rready)) break;
      tick();
    end
    if (is_write) begin
      if (rsp.bresp !== exp_resp) report_fail("bresp", 32'(exp_resp), 32'(rsp.bresp));
      if (!bad) exp_mem[key] = data;
    end else begin
      if (rsp.rresp !== exp_resp) report_fail("rresp", 32'(exp_resp), 32'(rsp.rresp));
      if (rsp.rdata !== exp_rdata) report_fail("rdata", exp_rdata, rsp.rdata);
    end
    tick();
    req.bready = 1'b0;
    req.rready = 1'b0;
    if (bad) begin
      if (pkt_cnt != cnt0) begin
        $display("a packet went out for invalid eva %h", eva);
        errors++;
      end
    end else begin
      if (pkt_cnt != cnt0 + 1) begin
        $display("expected one packet for eva %h, saw %0d", eva, pkt_cnt - cnt0);
        errors++;
      end
      if (last_pkt.npa !== exp_npa) report_fail("pkt_o.npa", 32'(exp_npa), 32'(last_pkt.npa));
      if (last_pkt.op !== exp_op) report_fail("pkt_o.op", 32'(exp_op), 32'(last_pkt.op));
      if (last_pkt.mask !== (is_write ? strb : 4'hf))
        report_fail("pkt_o.mask", 32'(is_write ? strb : 4'hf), 32'(last_pkt.mask));
      if (is_write && last_pkt.data !== data) report_fail("pkt_o.data", data, last_pkt.data);
    end
  endtask

  // mesh responder, answers 1 to 5 cycles after taking a packet
  initial begin : responder
    net_pkt_s p;
    logic [31:0] r;
    logic [26:0] key;
    pkt_ready = 1'b0;
    net_rsp = '0;
    net_rsp_v = 1'b0;
    forever begin
      tick();
      pkt_ready = ready_draw();
      if (pkt_v && pkt_ready) begin
        p = pkt;
        last_pkt = pkt;
        pkt_cnt++;
        key = p.npa;
        tick();                             // handshake edge
        pkt_ready = 1'b0;
        r = rnd();
        repeat (r % 5) tick();
        net_rsp.data = (p.op == op_load && net_mem.exists(key)) ? net_mem[key] : 32'd0;
        if (p.op == op_store) net_mem[key] = p.data;
        net_rsp_v = 1'b1;
        tick();
        net_rsp_v = 1'b0;
      end
    end
  end

  initial begin : main
    int base;
    logic [31:0] r;
    logic [31:0] eva;
    logic [31:0] data;
    req = '0;
    rst_n_i = 1'b0;
    {tgo_x, tgo_y, pod_x, pod_y} = '0;
    repeat (4) tick();
    if (pkt_v || rsp.bvalid || rsp.rvalid || rsp.awready || rsp.wready || rsp.arready) begin
      $display("outputs active while reset is asserted");
      errors++;
    end
    rst_n_i = 1'b1;
    tick();
    if (!(rsp.awready && rsp.wready && rsp.arready)) begin
      $display("ready signals not high one cycle after reset release");
      errors++;
    end
    $display("test 1 reset: %s", (errors == 0) ? "ok" : "errors");
    for (int t = 2; t <= num_tests_c; t++) begin
      base = errors;
      r = rnd();
      tgo_x = r[1:0];          // new origin and pod while idle
      tgo_y = r[3:2];
      pod_x = r[6:4];
      pod_y = r[10:7];
      for (int i = 0; i < accesses_c / 2; i++) begin
        r = rnd();
        eva = rnd();
        data = rnd();
        case (r[1:0])
          2'd0: eva[31] = 1'b1;            // dram
          2'd1: eva[31:30] = 2'b01;        // global
          2'd2: eva[31:29] = 3'b001;       // tile group
          default: eva[31:29] = 3'b000;    // no class
        endcase
        access(1'b1, eva, data, r[5:2]);
        access(1'b0, eva, 32'd0, 4'd0);    // read back the same eva
      end
      $display("test %0d random, pod %0d/%0d, origin %0d/%0d: %0d errors",
               t, pod_x, pod_y, tgo_x, tgo_y, errors - base);
    end
    $display("%0d tests, %0d packets, %0d errors", num_tests_c, pkt_cnt, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
common/mc_addr_pkg.sv
common/mc_bus_pkg.sv
eva_to_npa/dram_hash.sv
eva_to_npa/eva_to_npa.sv
verilog/axil_remote_adapter.sv
verilog/remote_access_top.sv
testbench/remote_access_chk.sv
testbench/tb_remote_access.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_remote_access
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
